/* rtl/systolic_config.svh */
`ifndef SYSTOLIC_CONFIG_SVH
`define SYSTOLIC_CONFIG_SVH

// array geometry
`define SYS_ROWS 4
`define SYS_COLS 4

// operand and partial-sum width
// products and sums wrap at this width
`define SYS_WORD_W 16

`endif

/* rtl/systolic_pkg.sv */
`default_nettype none

`include "systolic_config.svh"

package systolic_pkg;

    typedef logic [`SYS_WORD_W-1:0] word_t;

    // wide enough to hold SYS_ROWS itself, the tracker counts down from it
    typedef logic [$clog2(`SYS_ROWS+1)-1:0] row_idx_t;

    typedef enum logic [1:0] {
        MODE_IDLE    = 2'd0, // everything holds
        MODE_LOAD    = 2'd1, // weights shift down the columns
        MODE_COMPUTE = 2'd2  // activations right, partial sums down
    } pe_mode_t;

    typedef struct packed {
        logic     valid;
        row_idx_t row;
        word_t    psum;
    } col_proxy_t;

    typedef word_t      [`SYS_ROWS-1:0] word_row_t; // indexed by row
    typedef word_t      [`SYS_COLS-1:0] word_col_t; // indexed by column
    typedef col_proxy_t [`SYS_COLS-1:0] proxy_bus_t;

endpackage

`default_nettype wire

/* rtl/pe_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_mac
    import systolic_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pe_mode_t mode,
    input  word_t    left_in,
    input  word_t    top_in,
    output word_t    right_out,
    output word_t    bottom_out
);

    word_t weight;  // stationary operand
    word_t product;
    word_t mac_sum;

    // truncated to the word width, unsigned
    assign product = left_in * weight;
    assign mac_sum = top_in + product;

    always_ff @(posedge clk) begin
        if (rst) begin
            weight     <= '0;
            right_out  <= '0;
            bottom_out <= '0;
        end else begin
            case (mode)
                MODE_LOAD: begin
                    // weight lands here and also moves on to the row below
                    weight     <= top_in;
                    bottom_out <= top_in;
                end
                MODE_COMPUTE: begin
                    bottom_out <= mac_sum;
                    right_out  <= left_in; // activation to the next column
                end
                default: begin
                    // idle, hold everything
                    weight     <= weight;
                    right_out  <= right_out;
                    bottom_out <= bottom_out;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/systolic_grid.sv */
`timescale 1ns/1ps
`default_nettype none

`include "systolic_config.svh"

module systolic_grid
    import systolic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pe_mode_t  mode,
    input  word_row_t left_in,
    input  word_col_t top_in,
    output word_col_t bottom_out,
    output word_row_t right_out,
    output word_row_t col_psums [`SYS_COLS]
);

    // vert[r][c] enters element (r, c) from above, row SYS_ROWS is the bottom edge
    word_t vert [`SYS_ROWS+1][`SYS_COLS];

    // horiz[r][c] enters element (r, c) from the left, column SYS_COLS is the right edge
    word_t horiz [`SYS_ROWS][`SYS_COLS+1];

    for (genvar c = 0; c < `SYS_COLS; c++) begin : g_edge_col
        assign vert[0][c]    = top_in[c];
        assign bottom_out[c] = vert[`SYS_ROWS][c];
    end

    for (genvar r = 0; r < `SYS_ROWS; r++) begin : g_edge_row
        assign horiz[r][0] = left_in[r];
        assign right_out[r] = horiz[r][`SYS_COLS];
    end

    for (genvar r = 0; r < `SYS_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `SYS_COLS; c++) begin : g_col
            pe_mac u_pe (
                .clk        (clk),
                .rst        (rst),
                .mode       (mode),
                .left_in    (horiz[r][c]),
                .top_in     (vert[r][c]),
                .right_out  (horiz[r][c+1]),
                .bottom_out (vert[r+1][c])
            );

            // every partial sum is visible to the proxy select
            assign col_psums[c][r] = vert[r+1][c];
        end
    end

endmodule

`default_nettype wire

/* rtl/proxy_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "systolic_config.svh"

module proxy_tracker
    import systolic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pe_mode_t   mode,
    input  word_col_t  top_in,
    input  word_row_t  col_psums [`SYS_COLS],
    output proxy_bus_t proxy
);

    typedef enum logic {
        PROXY_TBD, // weights still arriving
        PROXY_SET  // rows locked until reset
    } proxy_state_t;

    proxy_state_t state;
    row_idx_t     row_cnt;   // mirrors how many rows are still empty
    row_idx_t     load_row;  // resting row of the weight now on top_in
    logic         track_en;

    word_t                min_w   [`SYS_COLS];
    row_idx_t             min_row [`SYS_COLS];
    logic [`SYS_COLS-1:0] take_min;

    assign load_row = row_cnt - row_idx_t'(1);
    assign track_en = (state == PROXY_TBD) && (mode == MODE_LOAD);

    // one counter serves all columns, weights enter every column together
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= PROXY_TBD;
            row_cnt <= row_idx_t'(`SYS_ROWS);
        end else if (state == PROXY_TBD) begin
            if (mode == MODE_LOAD) begin
                row_cnt <= load_row;
                if (load_row == '0) begin
                    state <= PROXY_SET; // last weight goes to row 0
                end
            end else if (mode == MODE_COMPUTE) begin
                state <= PROXY_SET; // short load, keep what was seen
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `SYS_COLS; c++) begin
            take_min[c] = 1'b0;
            if (track_en) begin
                if (load_row == row_idx_t'(`SYS_ROWS - 1)) begin
                    take_min[c] = 1'b1; // first weight of the load
                end else if (top_in[c] < min_w[c]) begin
                    // strict, so a tie keeps the earlier (higher) row
                    take_min[c] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < `SYS_COLS; c++) begin
                min_w[c]   <= '0;
                min_row[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `SYS_COLS; c++) begin
                if (take_min[c]) begin
                    min_w[c]   <= top_in[c];
                    min_row[c] <= load_row;
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `SYS_COLS; c++) begin
            proxy[c].valid = (state == PROXY_SET);
            proxy[c].row   = min_row[c];
            proxy[c].psum  = col_psums[c][min_row[c]]; // psum of the tracked element
        end
    end

endmodule

`default_nettype wire

/* rtl/wproxy_systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "systolic_config.svh"

module wproxy_systolic_array
    import systolic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pe_mode_t   mode,
    input  word_row_t  left_in,
    input  word_col_t  top_in,
    output word_col_t  bottom_out,
    output word_row_t  right_out,
    output proxy_bus_t proxy
);

    // all partial sums, grouped by column
    word_row_t col_psums [`SYS_COLS];

    systolic_grid u_grid (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .left_in    (left_in),
        .top_in     (top_in),
        .bottom_out (bottom_out),
        .right_out  (right_out),
        .col_psums  (col_psums)
    );

    // sees the same weights as row 0 while they load
    proxy_tracker u_tracker (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .top_in    (top_in),
        .col_psums (col_psums),
        .proxy     (proxy)
    );

endmodule

`default_nettype wire

/* bench/tb_wproxy_systolic.sv */
`timescale 1ns/1ps
`default_nettype none

`include "systolic_config.svh"

module tb_wproxy_systolic import systolic_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 5;
    localparam int MAXV       = 16;
    localparam int NVEC_BURST = 6;
    localparam int ROWS       = `SYS_ROWS;
    localparam int COLS       = `SYS_COLS;
    // resets, loads, three streams with idles, then a margin
    localparam int WATCHDOG_CYCLES = 3 * (RST_CYCLES + 2) + 2 * (ROWS + 1) + 10
        + 2 * (ROWS + COLS + 3) + (2 * NVEC_BURST + 2 * ROWS + COLS + 3) + 40;

    logic       clk;
    logic       rst;
    pe_mode_t   mode;
    word_row_t  left_in;
    word_col_t  top_in;
    word_col_t  bottom_out;
    word_row_t  right_out;
    proxy_bus_t proxy;

    word_t     w_model [ROWS][COLS]; // weight resting in element (r, c)
    word_row_t vec_x [MAXV];
    word_col_t vec_b [MAXV];
    int        exp_row [COLS];

    wproxy_systolic_array dut0 (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .left_in    (left_in),
        .top_in     (top_in),
        .bottom_out (bottom_out),
        .right_out  (right_out),
        .proxy      (proxy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "run stopped by watchdog");
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst     = 1'b1;
        mode    = MODE_IDLE;
        left_in = '0;
        top_in  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    // bias plus products of rows 0..last_row, wrapping at the word width
    function automatic word_t dot_upto(input int v, input int c, input int last_row);
        word_t acc;
        acc = vec_b[v][c];
        for (int r = 0; r <= last_row; r++) begin
            acc = acc + vec_x[v][r] * w_model[r][c];
        end
        return acc;
    endfunction

    // row ROWS-1 is seen first, strict compare keeps the earlier row on a tie
    function automatic void compute_proxy_rows();
        int best;
        for (int c = 0; c < COLS; c++) begin
            best = ROWS - 1;
            for (int r = ROWS - 2; r >= 0; r--) begin
                if (w_model[r][c] < w_model[best][c]) best = r;
            end
            exp_row[c] = best;
        end
    endfunction

    // cycle k puts the weight for row ROWS-1-k on top_in, ends at a negedge in idle
    task automatic load_weights(input int n_cycles, input bit check_valid);
        for (int k = 0; k < n_cycles; k++) begin
            @(negedge clk);
            if (check_valid) begin
                for (int c = 0; c < COLS; c++) check($sformatf("proxy[%0d].valid", c),
                    proxy[c].valid, 1'b0);
            end
            mode    = MODE_LOAD;
            left_in = '0;
            for (int c = 0; c < COLS; c++) top_in[c] = w_model[ROWS-1-k][c];
            @(posedge clk);
        end
        @(negedge clk);
        mode   = MODE_IDLE;
        top_in = '0;
    endtask

    task automatic make_vectors(input int n);
        for (int v = 0; v < n; v++) begin
            for (int r = 0; r < ROWS; r++) vec_x[v][r] = word_t'($urandom);
            for (int c = 0; c < COLS; c++) vec_b[v][c] = word_t'($urandom);
        end
    endtask

    // k compute steps done; vector v entered at step v
    task automatic check_outputs(input int k, input int n, input bit check_proxy);
        int v;
        for (int c = 0; c < COLS; c++) begin
            v = k - ROWS - c;
            if (v >= 0 && v < n) check($sformatf("bottom_out[%0d]", c), bottom_out[c],
                dot_upto(v, c, ROWS - 1));
        end
        for (int r = 0; r < ROWS; r++) begin
            v = k - COLS - r;
            if (v >= 0 && v < n) check($sformatf("right_out[%0d]", r), right_out[r], vec_x[v][r]);
        end
        if (check_proxy) begin
            for (int c = 0; c < COLS; c++) begin
                check($sformatf("proxy[%0d].row", c), proxy[c].row, exp_row[c]);
                v = k - exp_row[c] - c - 1;
                if (v >= 0 && v < n) check($sformatf("proxy[%0d].psum", c), proxy[c].psum,
                    dot_upto(v, c, exp_row[c]));
            end
        end
    endtask

    task automatic drive_step(input int k, input int n);
        int v;
        mode = MODE_COMPUTE;
        for (int r = 0; r < ROWS; r++) begin
            v = k - r; // skew, row r starts r cycles late
            left_in[r] = (v >= 0 && v < n) ? vec_x[v][r] : '0;
        end
        for (int c = 0; c < COLS; c++) begin
            v = k - c;
            top_in[c] = (v >= 0 && v < n) ? vec_b[v][c] : '0;
        end
    endtask

    task automatic run_stream(input int n, input bit use_idle, input bit check_proxy);
        for (int k = 0; k <= n - 1 + ROWS + COLS; k++) begin
            if (use_idle && k > 0 && k <= n + ROWS && k % 2 == 0) begin
                @(negedge clk);
                check_outputs(k, n, check_proxy);
                mode    = MODE_IDLE; // junk on the inputs must be ignored
                left_in = word_row_t'({$urandom, $urandom});
                top_in  = word_col_t'({$urandom, $urandom});
                @(posedge clk);
            end
            @(negedge clk);
            check_outputs(k, n, check_proxy);
            drive_step(k, n);
            @(posedge clk);
        end
        @(negedge clk);
        mode    = MODE_IDLE;
        left_in = '0;
        top_in  = '0;
    endtask

    task automatic test_reset_state();
        apply_reset();
        check("bottom_out", bottom_out, '0);
        check("right_out", right_out, '0);
        check("proxy", proxy, '0);
    endtask

    task automatic test_load_and_multiply();
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++) w_model[r][c] = word_t'($urandom);
        compute_proxy_rows();
        load_weights(ROWS, 1'b1);
        make_vectors(1);
        run_stream(1, 1'b0, 1'b0);
    endtask

    task automatic test_proxy_select();
        word_t low;
        apply_reset();
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) w_model[r][c] = word_t'($urandom_range(16'hffff, 256));
            low = word_t'($urandom_range(255, 0));
            w_model[c % ROWS][c]       = low; // same minimum in two rows
            w_model[(c + 1) % ROWS][c] = low;
        end
        compute_proxy_rows();
        load_weights(ROWS, 1'b1);
        for (int c = 0; c < COLS; c++) begin
            check($sformatf("proxy[%0d].valid", c), proxy[c].valid, 1'b1);
            check($sformatf("proxy[%0d].row", c), proxy[c].row, exp_row[c]);
        end
    endtask

    task automatic test_proxy_psum();
        make_vectors(1);
        run_stream(1, 1'b0, 1'b1);
    endtask

    task automatic test_stream_with_idle();
        make_vectors(NVEC_BURST);
        run_stream(NVEC_BURST, 1'b1, 1'b1);
    endtask

    task automatic test_short_load();
        apply_reset();
        for (int c = 0; c < COLS; c++) begin
            // nonzero so the zero weights loaded later are always smaller
            w_model[ROWS-1][c] = word_t'($urandom_range(15, 1));
            w_model[ROWS-2][c] = word_t'($urandom_range(15, 1));
            exp_row[c] = (w_model[ROWS-2][c] < w_model[ROWS-1][c]) ? ROWS - 2 : ROWS - 1;
        end
        load_weights(2, 1'b1);
        for (int c = 0; c < COLS; c++) begin
            check($sformatf("proxy[%0d].valid", c), proxy[c].valid, 1'b0);
        end
        drive_step(0, 0); // one compute edge with zero operands
        @(posedge clk);
        @(negedge clk);
        mode = MODE_IDLE;
        for (int c = 0; c < COLS; c++) begin
            check($sformatf("proxy[%0d].valid", c), proxy[c].valid, 1'b1);
            check($sformatf("proxy[%0d].row", c), proxy[c].row, exp_row[c]);
        end
        // smaller weights after lock must not move the proxy
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++) w_model[r][c] = '0;
        load_weights(2, 1'b0);
        for (int c = 0; c < COLS; c++) begin
            check($sformatf("proxy[%0d].valid", c), proxy[c].valid, 1'b1);
            check($sformatf("proxy[%0d].row", c), proxy[c].row, exp_row[c]);
        end
    endtask

    initial begin
        rst     = 1'b1;
        mode    = MODE_IDLE;
        left_in = '0;
        top_in  = '0;
        void'($urandom(32'h2b14_578c));

        test_reset_state();
        test_load_and_multiply();
        test_proxy_select();
        test_proxy_psum();
        test_stream_with_idle();
        test_short_load();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+rtl
rtl/systolic_pkg.sv
rtl/pe_mac.sv
rtl/systolic_grid.sv
rtl/proxy_tracker.sv
rtl/wproxy_systolic_array.sv
bench/tb_wproxy_systolic.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_wproxy_systolic -f build.f \
    && ./obj_dir/Vtb_wproxy_systolic > sim.log 2>&1 \
    || echo "build or simulation returned an error"
[ -f sim.log ] || { echo "no simulation log"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
